// ==== design/fe_ctrl.sv ====
//==========================================================================
// command decode and acceptance, wait/run/stall FSM and pipeline flush
//==========================================================================

`timescale 1ns/1ps

module fe_ctrl
  import fe_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       fe_cmd_v_i,
  input  fe_opcode_e fe_cmd_opcode_i,
  output logic       fe_cmd_yumi_o,
  input  logic       fe_queue_ready_i1,
  input  logic       fe_queue_ready_i2,
  input  logic       drop_i,
  input  logic       exc_issued_i,
  output logic       fill_we_o,
  output logic       redirect_v_o,
  output logic       fetch_en_o,
  output logic       flush_o
);

  fe_state_e state_r;
  fe_state_e state_n;

  logic is_redirect;
  logic is_fill;
  logic is_wait;
  logic fill_ok;
  logic accept;
  logic redirect_acc;
  logic wait_acc;
  logic both_ready;

  // opcode decode
  assign is_redirect = (fe_cmd_opcode_i == e_op_pc_redirect);
  assign is_fill = (fe_cmd_opcode_i == e_op_icache_fill);
  assign is_wait = (fe_cmd_opcode_i == e_op_wait);

  // a fill only lands while nothing is being fetched
  assign fill_ok = (state_r == e_wait) || (state_r == e_stall);
  assign accept = is_redirect | is_wait | (is_fill & fill_ok);

  // yumi consumes the command at this edge
  assign fe_cmd_yumi_o = fe_cmd_v_i & accept;

  assign redirect_acc = fe_cmd_yumi_o & is_redirect;
  assign wait_acc = fe_cmd_yumi_o & is_wait;
  assign fill_we_o = fe_cmd_yumi_o & is_fill;
  assign redirect_v_o = redirect_acc;

  assign both_ready = fe_queue_ready_i1 & fe_queue_ready_i2;

  // next state, accepted commands override the pipeline events
  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_wait:
        state_n = e_wait;
      e_run:
        // exception issued stops fetch, a dropped pair waits for the queue
        if (exc_issued_i)
          state_n = e_wait;
        else if (drop_i)
          state_n = e_stall;
      e_stall:
        if (both_ready)
          state_n = e_run;
      default:
        state_n = e_wait;
    endcase
    if (redirect_acc)
      state_n = e_run;
    else if (wait_acc)
      state_n = e_wait;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_wait;
    else
      state_r <= state_n;
  end

  // launch a pair whenever the FSM is headed to run
  assign fetch_en_o = (state_n == e_run);

  // anything that makes the in-flight pairs stale
  assign flush_o = redirect_acc | wait_acc | drop_i | exc_issued_i;

endmodule

// ==== design/fe_imem.sv ====
//==========================================================================
// instruction memory, filled by commands, read a pair at a time into IF2
//==========================================================================

`timescale 1ns/1ps

module fe_imem
  import fe_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               fill_we_i,
  input  logic [VADDR_W-1:0] fill_addr_i,
  input  logic [INSTR_W-1:0] fill_data_i,
  input  logic               flush_i,
  input  logic               restart_v_i,
  fe_stage_if.dst            if1,
  fe_stage_if.src            if2
);

  logic [INSTR_W-1:0] mem [IMEM_WORDS];

  logic [IMEM_AW-1:0] fill_idx;
  logic [IMEM_AW-1:0] rd_idx1;
  logic [IMEM_AW-1:0] rd_idx2;
  logic rd_mask;
  logic [INSTR_W-1:0] rd_word1;
  logic [INSTR_W-1:0] rd_word2;

  // byte address to word index
  assign fill_idx = fill_addr_i[IMEM_AW+1:2];

  always_ff @(posedge clk_i)
  begin
    if (fill_we_i)
      mem[fill_idx] <= fill_data_i;
  end

  // second word is the next index, wraps only on faulting pairs
  assign rd_idx1 = if1.pc[IMEM_AW+1:2];
  assign rd_idx2 = rd_idx1 + IMEM_AW'(1);

  // faulting pairs carry no instruction bits
  assign rd_mask = (if1.exc != e_exc_none);
  assign rd_word1 = rd_mask ? '0 : mem[rd_idx1];
  assign rd_word2 = rd_mask ? '0 : mem[rd_idx2];

  // IF2 valid, a flush or restart kills the pair leaving IF1
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      if2.v <= 1'b0;
    else
      if2.v <= if1.v & ~flush_i & ~restart_v_i;
  end

  // IF2 payload
  always_ff @(posedge clk_i)
  begin
    if2.pc <= if1.pc;
    if2.exc <= if1.exc;
    if2.instr1 <= rd_word1;
    if2.instr2 <= rd_word2;
  end

endmodule

// ==== design/fe_pc_gen.sv ====
//==========================================================================
// fetch pc register and IF1 launch, checks the pair address for faults
//==========================================================================

`timescale 1ns/1ps

module fe_pc_gen
  import fe_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               fetch_en_i,
  input  logic               redirect_v_i,
  input  logic [VADDR_W-1:0] redirect_pc_i,
  input  logic               restart_v_i,
  input  logic [VADDR_W-1:0] restart_pc_i,
  input  logic               flush_i,
  fe_stage_if.src            if1
);

  logic [VADDR_W-1:0] pc_r;
  logic launch;
  logic misaligned;
  logic access_fault;
  fe_exc_e exc_n;

  // a restart reloads the pc this cycle so nothing launches with the old one
  assign launch = fetch_en_i & ~flush_i & ~restart_v_i;

  // low bits set means the pair is not word aligned
  assign misaligned = (pc_r[1:0] != 2'b00);
  // second word at pc+4 must still be inside the memory
  assign access_fault = (pc_r >= VADDR_W'(IMEM_BYTES - 4));

  // misaligned wins over access fault
  always_comb
  begin
    if (misaligned)
      exc_n = e_instr_misaligned;
    else if (access_fault)
      exc_n = e_instr_access_fault;
    else
      exc_n = e_exc_none;
  end

  // redirect has priority over a restart from the queue stage
  always_ff @(posedge clk_i)
  begin
    if (redirect_v_i)
      pc_r <= redirect_pc_i;
    else if (restart_v_i)
      pc_r <= restart_pc_i;
    else if (launch)
      pc_r <= pc_r + VADDR_W'(PAIR_BYTES);
  end

  // IF1 valid
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      if1.v <= 1'b0;
    else
      if1.v <= launch;
  end

  // IF1 payload, only loaded when a pair goes out
  always_ff @(posedge clk_i)
  begin
    if (launch)
    begin
      if1.pc <= pc_r;
      if1.exc <= exc_n;
    end
  end

  // words are not known yet at IF1
  assign if1.instr1 = '0;
  assign if1.instr2 = '0;

endmodule

// ==== design/fe_pkg.sv ====
//==========================================================================
// shared widths, encodings and the queue entry type of the fetch front end
// every design and testbench file imports this package by wildcard
//==========================================================================

package fe_pkg;

  // address and instruction widths
  localparam int VADDR_W = 32;
  localparam int INSTR_W = 32;

  // on-chip instruction memory, 64 words of 4 bytes
  localparam int IMEM_WORDS = 64;
  localparam int IMEM_AW = 6;
  // byte size of the memory, the fault limit for fetch
  localparam int IMEM_BYTES = IMEM_WORDS * 4;

  // one fetch pair covers two instructions
  localparam int PAIR_BYTES = 8;

  // rv32 major opcodes that change the control flow
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;

  // command opcodes from the back end
  typedef enum logic [1:0] {
    e_op_pc_redirect = 2'd0,
    e_op_icache_fill = 2'd1,
    e_op_wait = 2'd2
  } fe_opcode_e;

  // fetch controller states
  typedef enum logic [1:0] {
    e_wait = 2'd0,
    e_run = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

  // fetch exception codes, none means a plain fetch
  typedef enum logic [1:0] {
    e_exc_none = 2'd0,
    e_instr_misaligned = 2'd1,
    e_instr_access_fault = 2'd2
  } fe_exc_e;

  // queue message type
  typedef enum logic {
    e_fe_fetch = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_e;

  // one queue slot, 67 bits
  // instr is zero in an exception entry
  typedef struct packed {
    fe_msg_e msg_type;
    logic [VADDR_W-1:0] pc;
    logic [INSTR_W-1:0] instr;
    fe_exc_e exc;
  } fe_queue_entry_t;

endpackage

// ==== design/fe_queue_stage.sv ====
//==========================================================================
// issue stage, builds the two queue entries from IF2 and hands them over
// when both slots are ready, else drops the pair and asks for a replay
//==========================================================================

`timescale 1ns/1ps

module fe_queue_stage
  import fe_pkg::*;
(
  fe_stage_if.dst            if2,
  input  logic               fe_queue_ready_i1,
  input  logic               fe_queue_ready_i2,
  output fe_queue_entry_t    fe_queue_o1,
  output fe_queue_entry_t    fe_queue_o2,
  output logic               fe_queue_v_o1,
  output logic               fe_queue_v_o2,
  output logic               drop_o,
  output logic               exc_issued_o,
  output logic               restart_v_o,
  output logic [VADDR_W-1:0] restart_pc_o
);

  logic [6:0] opc1;
  logic is_ct;
  logic is_exc;
  logic both_ready;
  logic issue;
  logic ct_restart;
  logic [VADDR_W-1:0] pc2;

  // major opcode of slot 1
  assign opc1 = if2.instr1[6:0];
  assign is_ct = (opc1 == OPC_BRANCH) || (opc1 == OPC_JAL) || (opc1 == OPC_JALR);

  assign is_exc = (if2.exc != e_exc_none);
  assign pc2 = if2.pc + VADDR_W'(4);

  // both slots go together or not at all
  assign both_ready = fe_queue_ready_i1 & fe_queue_ready_i2;
  assign issue = if2.v & both_ready;

  // slot 2 only follows a plain fetch that does not leave the stream
  assign fe_queue_v_o1 = issue;
  assign fe_queue_v_o2 = issue & ~is_exc & ~is_ct;

  // pair cannot be taken, throw it away and refetch it later
  assign drop_o = if2.v & ~both_ready;

  assign exc_issued_o = issue & is_exc;

  // slot 2 was squashed, fetch resumes at that instruction
  assign ct_restart = issue & ~is_exc & is_ct;

  assign restart_v_o = drop_o | ct_restart;
  assign restart_pc_o = drop_o ? if2.pc : pc2;

  // slot 1 entry
  always_comb
  begin
    fe_queue_o1 = '0;
    fe_queue_o1.pc = if2.pc;
    if (is_exc)
    begin
      fe_queue_o1.msg_type = e_fe_exception;
      fe_queue_o1.exc = if2.exc;
    end
    else
    begin
      fe_queue_o1.msg_type = e_fe_fetch;
      fe_queue_o1.instr = if2.instr1;
      fe_queue_o1.exc = e_exc_none;
    end
  end

  // slot 2 entry, zero whenever slot 2 is not a fetch
  always_comb
  begin
    fe_queue_o2 = '0;
    if (!is_exc && !is_ct)
    begin
      fe_queue_o2.msg_type = e_fe_fetch;
      fe_queue_o2.pc = pc2;
      fe_queue_o2.instr = if2.instr2;
      fe_queue_o2.exc = e_exc_none;
    end
  end

endmodule

// ==== design/fe_stage_if.sv ====
//==========================================================================
// one fetch pair passed between two adjacent pipeline stages
//==========================================================================

`timescale 1ns/1ps

interface fe_stage_if
  import fe_pkg::*;
  ();

  // pair valid, moves every cycle with no back-pressure
  logic v;
  // pc of the first instruction, the second sits at pc+4
  logic [VADDR_W-1:0] pc;
  // address exception found at launch
  fe_exc_e exc;
  // the two instruction words, filled by the memory stage
  logic [INSTR_W-1:0] instr1;
  logic [INSTR_W-1:0] instr2;

  // producing stage
  modport src (output v, pc, exc, instr1, instr2);

  // consuming stage
  modport dst (input v, pc, exc, instr1, instr2);

endinterface

// ==== design/fe_top.sv ====
//==========================================================================
// dual-issue fetch front end, commands in over valid/yumi and instruction
// pairs out over two valid/ready queue slots
//==========================================================================

`timescale 1ns/1ps

module fe_top
  import fe_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               fe_cmd_v_i,
  input  fe_opcode_e         fe_cmd_opcode_i,
  input  logic [VADDR_W-1:0] fe_cmd_vaddr_i,
  input  logic [INSTR_W-1:0] fe_cmd_instr_i,
  output logic               fe_cmd_yumi_o,
  output fe_queue_entry_t    fe_queue_o1,
  output fe_queue_entry_t    fe_queue_o2,
  output logic               fe_queue_v_o1,
  output logic               fe_queue_v_o2,
  input  logic               fe_queue_ready_i1,
  input  logic               fe_queue_ready_i2
);

  logic fill_we;
  logic redirect_v;
  logic fetch_en;
  logic flush;
  logic drop;
  logic exc_issued;
  logic restart_v;
  logic [VADDR_W-1:0] restart_pc;

  // pc gen to memory, memory to issue
  fe_stage_if if1_bus ();
  fe_stage_if if2_bus ();

  fe_ctrl u_ctrl (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .fe_cmd_v_i        (fe_cmd_v_i),
    .fe_cmd_opcode_i   (fe_cmd_opcode_i),
    .fe_cmd_yumi_o     (fe_cmd_yumi_o),
    .fe_queue_ready_i1 (fe_queue_ready_i1),
    .fe_queue_ready_i2 (fe_queue_ready_i2),
    .drop_i            (drop),
    .exc_issued_i      (exc_issued),
    .fill_we_o         (fill_we),
    .redirect_v_o      (redirect_v),
    .fetch_en_o        (fetch_en),
    .flush_o           (flush)
  );

  // redirect target and fill address share the command vaddr
  fe_pc_gen u_pc_gen (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_en_i    (fetch_en),
    .redirect_v_i  (redirect_v),
    .redirect_pc_i (fe_cmd_vaddr_i),
    .restart_v_i   (restart_v),
    .restart_pc_i  (restart_pc),
    .flush_i       (flush),
    .if1           (if1_bus.src)
  );

  fe_imem u_imem (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .fill_we_i   (fill_we),
    .fill_addr_i (fe_cmd_vaddr_i),
    .fill_data_i (fe_cmd_instr_i),
    .flush_i     (flush),
    .restart_v_i (restart_v),
    .if1         (if1_bus.dst),
    .if2         (if2_bus.src)
  );

  fe_queue_stage u_queue_stage (
    .if2               (if2_bus.dst),
    .fe_queue_ready_i1 (fe_queue_ready_i1),
    .fe_queue_ready_i2 (fe_queue_ready_i2),
    .fe_queue_o1       (fe_queue_o1),
    .fe_queue_o2       (fe_queue_o2),
    .fe_queue_v_o1     (fe_queue_v_o1),
    .fe_queue_v_o2     (fe_queue_v_o2),
    .drop_o            (drop),
    .exc_issued_o      (exc_issued),
    .restart_v_o       (restart_v),
    .restart_pc_o      (restart_pc)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the fetch front end testbench with verilator and run it
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module tb_fe_top -o tb_fe_top
./obj_dir/tb_fe_top | tee sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"

// ==== sim/fe_cases.txt ====
// hex words in order, words 0-63 are the memory fill, one word per index
// then stream start pcs, exception pcs with their codes, the late fill and ready threshold
00000013 00100013 00200013 00300013 00400013 00500013 00600013 00700013
00800013 00900013 0000006f 00b00013 00c00013 00000063 00e00013 00f00013
01000013 01100013 01200013 01300013 01400013 00008067 01600013 01700013
01800013 01900013 01a00013 01b00013 01c00013 01d00013 01e00013 01f00013
02000013 02100013 02200013 02300013 02400013 02500013 02600013 02700013
02800013 02900013 02a00013 02b00013 02c00013 02d00013 02e00013 02f00013
03000013 03100013 03200013 03300013 03400013 03500013 03600013 03700013
03800013 03900013 03a00013 03b00013 03c00013 03d00013 03e00013 03f00013
// start pcs of the aligned, random ready and control transfer streams
00000080
00000000
00000028
// misaligned pc and code, access fault pc and code
00000022
00000001
000000fc
00000002
// late fill address and word
00000030
00c00093
// a ready input is low when its 3 random bits fall below this
00000003

// ==== sim/tb_fe_top.sv ====
//==========================================================================
// testbench for the fetch front end, runs the cases data file through the
// DUT and checks both queue slots against a model of the filled memory
//==========================================================================

`timescale 1ns/1ps

module tb_fe_top
  import fe_pkg::*;
  ();

  logic clk_i;
  logic reset_i;
  logic fe_cmd_v_i;
  fe_opcode_e fe_cmd_opcode_i;
  logic [VADDR_W-1:0] fe_cmd_vaddr_i;
  logic [INSTR_W-1:0] fe_cmd_instr_i;
  logic fe_cmd_yumi_o;
  fe_queue_entry_t fe_queue_o1;
  fe_queue_entry_t fe_queue_o2;
  logic fe_queue_v_o1;
  logic fe_queue_v_o2;
  logic fe_queue_ready_i1;
  logic fe_queue_ready_i2;

  // 0-63 fill words, 64-66 stream pcs, 67-70 exception cases
  // 71-72 late fill, 73 ready low threshold
  logic [INSTR_W-1:0] cases_mem [74];
  // what the memory should hold after the fills
  logic [INSTR_W-1:0] shadow [IMEM_WORDS];
  integer seed;
  int errors;
  int tests_failed;
  int err0;
  int issued;
  int squashed;
  int idx;
  bit acc;
  fe_exc_e last_exc;

  fe_top DUT (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic bit is_ct(input logic [INSTR_W-1:0] w);
    return (w[6:0] == OPC_BRANCH) || (w[6:0] == OPC_JAL) || (w[6:0] == OPC_JALR);
  endfunction

  // plain fetch of the word at pc
  function automatic fe_queue_entry_t fetch_entry(input logic [VADDR_W-1:0] pc);
    fe_queue_entry_t e;
    e = '0;
    e.msg_type = e_fe_fetch;
    e.pc = pc;
    e.instr = shadow[pc[IMEM_AW+1:2]];
    e.exc = e_exc_none;
    return e;
  endfunction

  // slot 1 expectation with misaligned ahead of pc+4 past byte 255
  function automatic fe_queue_entry_t model_slot1(input logic [VADDR_W-1:0] pc);
    fe_queue_entry_t e;
    e = '0;
    e.msg_type = e_fe_exception;
    e.pc = pc;
    if (pc[1:0] != 2'b00)
      e.exc = e_instr_misaligned;
    else if ((pc + 32'd4) > 32'd255)
      e.exc = e_instr_access_fault;
    else
      e = fetch_entry(pc);
    return e;
  endfunction

  task automatic check_entry(input string name, input fe_queue_entry_t got,
                             input fe_queue_entry_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_exc(input string name, input fe_exc_e got, input fe_exc_e exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // starts at a falling edge and holds the command until yumi or max_cycles
  task automatic send_cmd(input fe_opcode_e op, input logic [VADDR_W-1:0] vaddr,
                          input logic [INSTR_W-1:0] instr, input int max_cycles,
                          output bit accepted);
    int n;
    accepted = 1'b0;
    n = 0;
    fe_cmd_v_i = 1'b1;
    fe_cmd_opcode_i = op;
    fe_cmd_vaddr_i = vaddr;
    fe_cmd_instr_i = instr;
    while (!accepted && n < max_cycles)
    begin
      #1;
      accepted = fe_cmd_yumi_o;
      // the rising edge in between consumes an accepted command
      @(negedge clk_i);
      n++;
    end
    fe_cmd_v_i = 1'b0;
  endtask

  task automatic require_cmd(input fe_opcode_e op, input logic [VADDR_W-1:0] vaddr,
                             input logic [INSTR_W-1:0] instr);
    bit ok;
    send_cmd(op, vaddr, instr, 20, ok);
    if (!ok)
    begin
      $display("command %s was not accepted within 20 cycles", op.name());
      errors++;
    end
  endtask

  // no valid on either slot for a number of cycles
  task automatic quiet_check(input int cycles);
    int k;
    for (k = 0; k < cycles; k++)
    begin
      #1;
      if (fe_queue_v_o1 || fe_queue_v_o2)
      begin
        $display("queue valid raised while fetch is stopped");
        errors++;
      end
      @(negedge clk_i);
    end
  endtask

  // redirect to start_pc and follow the stream until its exception entry
  task automatic run_stream(input logic [VADDR_W-1:0] start_pc, input bit rand_ready);
    logic [VADDR_W-1:0] exp_pc;
    fe_queue_entry_t exp1;
    bit done;
    int n;
    int r;
    exp_pc = start_pc;
    done = 1'b0;
    n = 0;
    issued = 0;
    squashed = 0;
    last_exc = e_exc_none;
    fe_queue_ready_i1 = 1'b1;
    fe_queue_ready_i2 = 1'b1;
    require_cmd(e_op_pc_redirect, start_pc, '0);
    while (!done && n < 2000)
    begin
      if (rand_ready)
      begin
        r = $random(seed);
        fe_queue_ready_i1 = (r[2:0] >= cases_mem[73][2:0]);
        fe_queue_ready_i2 = (r[5:3] >= cases_mem[73][2:0]);
      end
      #1;
      // a slot may only be offered while both readies are high
      if ((fe_queue_v_o1 || fe_queue_v_o2) && !(fe_queue_ready_i1 && fe_queue_ready_i2))
      begin
        $display("queue valid raised while a ready input was low");
        errors++;
      end
      if (fe_queue_v_o1)
      begin
        exp1 = model_slot1(exp_pc);
        check_entry("fe_queue_o1", fe_queue_o1, exp1);
        issued++;
        if (exp1.msg_type == e_fe_exception)
        begin
          // exception goes alone and ends the stream
          check_bit("fe_queue_v_o2", fe_queue_v_o2, 1'b0);
          last_exc = fe_queue_o1.exc;
          done = 1'b1;
        end
        else if (is_ct(exp1.instr))
        begin
          // squashed slot 2 comes back as the next slot 1
          check_bit("fe_queue_v_o2", fe_queue_v_o2, 1'b0);
          squashed++;
          exp_pc = exp_pc + 32'd4;
        end
        else
        begin
          check_bit("fe_queue_v_o2", fe_queue_v_o2, 1'b1);
          check_entry("fe_queue_o2", fe_queue_o2, fetch_entry(exp_pc + 32'd4));
          exp_pc = exp_pc + 32'd8;
        end
      end
      else
      begin
        // slot 2 never goes out without slot 1
        check_bit("fe_queue_v_o2", fe_queue_v_o2, 1'b0);
      end
      @(negedge clk_i);
      n++;
    end
    if (!done)
    begin
      $display("stream from %h did not end in an exception within 2000 cycles", start_pc);
      errors++;
    end
    fe_queue_ready_i1 = 1'b1;
    fe_queue_ready_i2 = 1'b1;
    quiet_check(20);
  endtask

  task automatic expect_single_exc(input logic [VADDR_W-1:0] pc,
                                   input logic [INSTR_W-1:0] exc_word);
    run_stream(pc, 1'b0);
    check_exc("fe_queue_o1.exc", last_exc, fe_exc_e'(exc_word[1:0]));
    if (issued != 1)
    begin
      $display("redirect to %h gave %0d entries instead of one exception", pc, issued);
      errors++;
    end
  endtask

  task automatic report_test(input int num, input string name);
    if (errors != err0)
      tests_failed++;
    $display("test %0d %s: %s, %0d entries", num, name,
             (errors == err0) ? "ok" : "failed", issued);
  endtask

  initial
  begin
    seed = 41120;
    errors = 0;
    tests_failed = 0;
    reset_i = 1'b1;
    fe_cmd_v_i = 1'b0;
    fe_cmd_opcode_i = e_op_wait;
    fe_cmd_vaddr_i = '0;
    fe_cmd_instr_i = '0;
    fe_queue_ready_i1 = 1'b1;
    fe_queue_ready_i2 = 1'b1;
    $readmemh("sim/fe_cases.txt", cases_mem);
    if ($isunknown(cases_mem[73]))
    begin
      $display("cases file is missing or too short");
      errors++;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    #1;
    check_bit("fe_cmd_yumi_o", fe_cmd_yumi_o, 1'b0);
    check_bit("fe_queue_v_o1", fe_queue_v_o1, 1'b0);
    check_bit("fe_queue_v_o2", fe_queue_v_o2, 1'b0);
    @(negedge clk_i);

    // fill every word while idle and stream from an aligned pc
    err0 = errors;
    for (idx = 0; idx < IMEM_WORDS; idx++)
    begin
      shadow[idx] = cases_mem[idx];
      require_cmd(e_op_icache_fill, VADDR_W'(idx * 4), cases_mem[idx]);
    end
    run_stream(cases_mem[64], 1'b0);
    report_test(1, "fill and sequential stream");

    // drops and replays must not lose or repeat an instruction
    err0 = errors;
    run_stream(cases_mem[65], 1'b1);
    report_test(2, "random ready stream");

    err0 = errors;
    run_stream(cases_mem[66], 1'b0);
    if (squashed == 0)
    begin
      $display("no control transfer was seen in slot 1");
      errors++;
    end
    report_test(3, "control transfer squash");

    err0 = errors;
    expect_single_exc(cases_mem[67], cases_mem[68]);
    expect_single_exc(cases_mem[69], cases_mem[70]);
    report_test(4, "fetch exceptions");

    // fill is held off while fetching and a wait stops the queue
    err0 = errors;
    require_cmd(e_op_pc_redirect, '0, '0);
    send_cmd(e_op_icache_fill, cases_mem[71], cases_mem[72], 10, acc);
    if (acc)
    begin
      $display("fill was accepted while fetching");
      errors++;
    end
    require_cmd(e_op_wait, '0, '0);
    quiet_check(30);
    require_cmd(e_op_icache_fill, cases_mem[71], cases_mem[72]);
    shadow[cases_mem[71][IMEM_AW+1:2]] = cases_mem[72];
    run_stream(cases_mem[71], 1'b0);
    report_test(5, "wait and late fill");

    $display("tests run 5, tests failed %0d, errors %0d", tests_failed, errors);
    if (errors == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
design/fe_pkg.sv
design/fe_stage_if.sv
design/fe_ctrl.sv
design/fe_pc_gen.sv
design/fe_imem.sv
design/fe_queue_stage.sv
design/fe_top.sv
sim/tb_fe_top.sv
